/* include/state_timer_defines.svh */
`ifndef STATE_TIMER_DEFINES_SVH
`define STATE_TIMER_DEFINES_SVH

// ---------------------------------------------------------------------------
// Flow table geometry
// ---------------------------------------------------------------------------

// Flow ID width, sets the table address width
`define STATE_TIMER_ID_W 8

// Table entries, one per flow ID
`define STATE_TIMER_DEPTH 256

// Timer and stored timestamp width
`define STATE_TIMER_W 16

// ---------------------------------------------------------------------------
// Update path flow control
// ---------------------------------------------------------------------------

// Update queue depth, equal to the sender's starting credits
`define STATE_TIMER_UPD_CREDITS 4

`endif

/* hw/state_timer_pkg.sv */
`include "state_timer_defines.svh"

package state_timer_pkg;

    // ------------------------------------------------------------------------
    // Basic word types
    // ------------------------------------------------------------------------

    // Flow ID, also the table address
    typedef logic [`STATE_TIMER_ID_W-1:0] id_t;

    // Timer value, stored timestamp or elapsed delta
    typedef logic [`STATE_TIMER_W-1:0] timer_t;

    // ------------------------------------------------------------------------
    // Control plane encodings
    // ------------------------------------------------------------------------

    // Single entry commands
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_GET   = 2'd1,
        CMD_SET   = 2'd2,
        CMD_CLEAR = 2'd3
    } ctrl_cmd_t;

    // Completion status, returned with ack
    typedef enum logic {
        STATUS_OK    = 1'b0,
        STATUS_ERROR = 1'b1
    } ctrl_status_t;

endpackage : state_timer_pkg

/* hw/state_ctrl_intf.sv */
`timescale 1ns/1ps

// Control plane for single entry access
// One request outstanding at a time, req/rdy accept then one ack pulse
interface state_ctrl_intf;

    // Request side, driven by the controller
    logic                          req;
    state_timer_pkg::ctrl_cmd_t    cmd;
    state_timer_pkg::id_t          key;
    state_timer_pkg::timer_t       set_value;

    // Response side, driven by the peripheral
    logic                          rdy;
    logic                          ack;
    state_timer_pkg::ctrl_status_t status;
    logic                          get_valid;
    state_timer_pkg::timer_t       get_value;

    modport controller (
        output req, cmd, key, set_value,
        input  rdy, ack, status, get_valid, get_value
    );

    modport peripheral (
        input  req, cmd, key, set_value,
        output rdy, ack, status, get_valid, get_value
    );

endinterface : state_ctrl_intf

/* hw/state_db_intf.sv */
`timescale 1ns/1ps

// Table access between the state core and the timestamp RAM
// Single port, write wins over read, read data one cycle after rd_en
interface state_db_intf;

    // Write port
    logic                    wr_en;
    state_timer_pkg::id_t    wr_addr;
    state_timer_pkg::timer_t wr_data;

    // Read port
    logic                    rd_en;
    state_timer_pkg::id_t    rd_addr;
    state_timer_pkg::timer_t rd_data;

    // High once the post-reset sweep has finished
    logic                    init_done;

    modport requester (
        output wr_en, wr_addr, wr_data, rd_en, rd_addr,
        input  rd_data, init_done
    );

    modport memory (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_data, init_done
    );

endinterface : state_db_intf

/* hw/state_db_ram.sv */
`timescale 1ns/1ps

`include "state_timer_defines.svh"

module state_db_ram (
    input  logic               clk,
    input  logic               srst,
    state_db_intf.memory       db
);

    // ------------------------------------------------------------------------
    // Storage and sweep state
    // ------------------------------------------------------------------------

    // One timestamp per flow ID
    state_timer_pkg::timer_t mem [`STATE_TIMER_DEPTH];

    // Sweep address, walks every entry once after reset
    state_timer_pkg::id_t    init_addr;
    logic                    init_done;

    // Registered read data
    state_timer_pkg::timer_t rd_data;

    // ------------------------------------------------------------------------
    // Reset sweep
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (srst) begin
            init_addr <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_addr <= init_addr + 1'b1;
            // Last entry written this cycle
            if (init_addr == state_timer_pkg::id_t'(`STATE_TIMER_DEPTH - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Single port array
    // ------------------------------------------------------------------------

    // Sweep owns the port until done, requester is ignored meanwhile
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[init_addr] <= '0;
        end else if (db.wr_en) begin
            mem[db.wr_addr] <= db.wr_data;
        end
    end

    // Read only when no write shares the cycle
    always_ff @(posedge clk) begin
        if (init_done && db.rd_en && !db.wr_en) begin
            rd_data <= mem[db.rd_addr];
        end
    end

    assign db.rd_data   = rd_data;
    assign db.init_done = init_done;

endmodule : state_db_ram

/* hw/state_core.sv */
`timescale 1ns/1ps

`include "state_timer_defines.svh"

module state_core (
    input  logic                    clk,
    input  logic                    srst,
    output logic                    init_done,
    input  logic                    upd_valid,
    input  state_timer_pkg::id_t    upd_id,
    output logic                    upd_credit,
    input  state_timer_pkg::timer_t new_state,
    state_ctrl_intf.peripheral      ctrl,
    state_db_intf.requester         db
);

    localparam int QDEPTH = `STATE_TIMER_UPD_CREDITS;
    localparam int PTR_W  = $clog2(QDEPTH);
    localparam int CNT_W  = $clog2(QDEPTH + 1);

    // ------------------------------------------------------------------------
    // Signals
    // ------------------------------------------------------------------------

    // Update queue, holds flow IDs waiting for a table write
    state_timer_pkg::id_t          q_mem [QDEPTH];
    logic [PTR_W-1:0]              q_wr_ptr;
    logic [PTR_W-1:0]              q_rd_ptr;
    logic [CNT_W-1:0]              q_count;
    logic                          q_push;
    logic                          q_pop;

    // Control request in flight
    logic                          accept;
    logic                          cmd_ok;
    logic                          ack_q;
    logic                          get_valid_q;
    state_timer_pkg::ctrl_cmd_t    cmd_q;
    state_timer_pkg::id_t          key_q;
    state_timer_pkg::ctrl_status_t status_q;

    // Table usage this cycle
    logic                          ctrl_wr;
    logic                          ctrl_busy;

    assign init_done = db.init_done;

    // ------------------------------------------------------------------------
    // Control plane
    // ------------------------------------------------------------------------

    // Idle between requests, low on the ack cycle
    assign ctrl.rdy = db.init_done && !ack_q;
    assign accept   = ctrl.req && ctrl.rdy;

    // NOP and anything unknown complete with an error
    always_comb begin
        case (ctrl.cmd)
            state_timer_pkg::CMD_GET,
            state_timer_pkg::CMD_SET,
            state_timer_pkg::CMD_CLEAR: cmd_ok = 1'b1;
            default:                    cmd_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            ack_q       <= 1'b0;
            get_valid_q <= 1'b0;
        end else begin
            ack_q       <= accept;
            get_valid_q <= accept && (ctrl.cmd == state_timer_pkg::CMD_GET);
        end
    end

    // Request payload, kept for the write on the ack cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q    <= ctrl.cmd;
            key_q    <= ctrl.key;
            status_q <= cmd_ok ? state_timer_pkg::STATUS_OK : state_timer_pkg::STATUS_ERROR;
        end
    end

    assign ctrl.ack       = ack_q;
    assign ctrl.status    = status_q;
    assign ctrl.get_valid = get_valid_q;
    // Stored value of the entry, read on the accept cycle
    assign ctrl.get_value = db.rd_data;

    // SET and CLEAR write back on the ack cycle
    assign ctrl_wr   = ack_q && ((cmd_q == state_timer_pkg::CMD_SET) ||
                                 (cmd_q == state_timer_pkg::CMD_CLEAR));
    assign ctrl_busy = accept || ctrl_wr;

    // ------------------------------------------------------------------------
    // Update queue
    // ------------------------------------------------------------------------

    // Full queue means a sender overran its credits
    assign q_push = upd_valid && (q_count != CNT_W'(QDEPTH));
    // Drain only when control leaves the table free
    assign q_pop  = db.init_done && (q_count != '0) && !ctrl_busy;

    always_ff @(posedge clk) begin
        if (q_push) begin
            q_mem[q_wr_ptr] <= upd_id;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end else begin
            if (q_push) begin
                q_wr_ptr <= (q_wr_ptr == PTR_W'(QDEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
            end
            if (q_pop) begin
                q_rd_ptr <= (q_rd_ptr == PTR_W'(QDEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
            end
            q_count <= q_count + CNT_W'(q_push) - CNT_W'(q_pop);
        end
    end

    // One credit back per queued update written
    assign upd_credit = q_pop;

    // ------------------------------------------------------------------------
    // Table access
    // ------------------------------------------------------------------------

    assign db.rd_en   = accept;
    assign db.rd_addr = ctrl.key;
    assign db.wr_en   = ctrl_wr || q_pop;
    assign db.wr_addr = ctrl_wr ? key_q : q_mem[q_rd_ptr];

    always_comb begin
        if (!ctrl_wr) begin
            db.wr_data = new_state;
        end else if (cmd_q == state_timer_pkg::CMD_SET) begin
            db.wr_data = ctrl.set_value;
        end else begin
            db.wr_data = '0;
        end
    end

endmodule : state_core

/* hw/state_timer_core.sv */
`timescale 1ns/1ps

module state_timer_core (
    input  logic                 clk,
    input  logic                 srst,
    input  logic                 tick,
    output logic                 init_done,
    output logic                 upd_credit,
    input  logic                 upd_valid,
    input  state_timer_pkg::id_t upd_id,
    state_ctrl_intf.peripheral   ctrl,
    state_db_intf.requester      db
);

    // ------------------------------------------------------------------------
    // Signals
    // ------------------------------------------------------------------------

    // Free running timer, wraps at 2^16
    state_timer_pkg::timer_t timer;

    // Control plane seen by the generic state engine
    state_ctrl_intf core_ctrl ();

    // ------------------------------------------------------------------------
    // Generic state engine
    // ------------------------------------------------------------------------

    // Every update stamps the entry with the current timer
    state_core state_core_inst (
        .clk        (clk),
        .srst       (srst),
        .init_done  (init_done),
        .upd_valid  (upd_valid),
        .upd_id     (upd_id),
        .upd_credit (upd_credit),
        .new_state  (timer),
        .ctrl       (core_ctrl.peripheral),
        .db         (db)
    );

    // ------------------------------------------------------------------------
    // Timer
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (srst) begin
            timer <= '0;
        end else if (tick) begin
            timer <= timer + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Control remapping
    // ------------------------------------------------------------------------

    // SET always restamps with the live timer
    assign core_ctrl.req       = ctrl.req;
    assign core_ctrl.cmd       = ctrl.cmd;
    assign core_ctrl.key       = ctrl.key;
    assign core_ctrl.set_value = timer;

    // No extra latency on accept
    assign ctrl.rdy = core_ctrl.rdy;

    // Elapsed time since stamp, modulo 2^16
    always_ff @(posedge clk) begin
        ctrl.get_value <= timer - core_ctrl.get_value;
        ctrl.status    <= core_ctrl.status;
    end

    // Handshake flags follow the delta by one register
    always_ff @(posedge clk) begin
        if (srst) begin
            ctrl.ack       <= 1'b0;
            ctrl.get_valid <= 1'b0;
        end else begin
            ctrl.ack       <= core_ctrl.ack;
            ctrl.get_valid <= core_ctrl.get_valid;
        end
    end

endmodule : state_timer_core

/* hw/state_timer_top.sv */
`timescale 1ns/1ps

module state_timer_top (
    input  logic                          clk,
    input  logic                          srst,
    input  logic                          tick,
    input  logic                          upd_valid,
    input  state_timer_pkg::id_t          upd_id,
    output logic                          upd_credit,
    output logic                          init_done,
    input  logic                          ctrl_req,
    input  state_timer_pkg::ctrl_cmd_t    ctrl_cmd,
    input  state_timer_pkg::id_t          ctrl_key,
    output logic                          ctrl_rdy,
    output logic                          ctrl_ack,
    output state_timer_pkg::ctrl_status_t ctrl_status,
    output logic                          ctrl_get_valid,
    output state_timer_pkg::timer_t       ctrl_get_value
);

    // ------------------------------------------------------------------------
    // Internal buses
    // ------------------------------------------------------------------------

    state_ctrl_intf ctrl_bus ();
    state_db_intf   db_bus ();

    // Control plane ports onto the bus
    assign ctrl_bus.req       = ctrl_req;
    assign ctrl_bus.cmd       = ctrl_cmd;
    assign ctrl_bus.key       = ctrl_key;
    // Timer core substitutes its own timer here
    assign ctrl_bus.set_value = '0;

    assign ctrl_rdy       = ctrl_bus.rdy;
    assign ctrl_ack       = ctrl_bus.ack;
    assign ctrl_status    = ctrl_bus.status;
    assign ctrl_get_valid = ctrl_bus.get_valid;
    assign ctrl_get_value = ctrl_bus.get_value;

    // ------------------------------------------------------------------------
    // Timer core and table
    // ------------------------------------------------------------------------

    state_timer_core state_timer_core_inst (
        .clk        (clk),
        .srst       (srst),
        .tick       (tick),
        .init_done  (init_done),
        .upd_credit (upd_credit),
        .upd_valid  (upd_valid),
        .upd_id     (upd_id),
        .ctrl       (ctrl_bus.peripheral),
        .db         (db_bus.requester)
    );

    state_db_ram state_db_ram_inst (
        .clk  (clk),
        .srst (srst),
        .db   (db_bus.memory)
    );

endmodule : state_timer_top

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

// Free running testbench clock, 10 ns period
module tb_clk_gen (
    output logic clk
);

    localparam time HALF_PERIOD = 5ns;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule : tb_clk_gen

/* sim/state_timer_tb.sv */
`timescale 1ns/1ps

`include "state_timer_defines.svh"

module state_timer_tb;

    localparam int DEPTH       = `STATE_TIMER_DEPTH;
    localparam int UPD_CREDITS = `STATE_TIMER_UPD_CREDITS;
    localparam int INIT_LIMIT  = DEPTH + 32;
    localparam int WAIT_LIMIT  = 64;

    // Short names for table rows
    localparam state_timer_pkg::ctrl_cmd_t    NOP = state_timer_pkg::CMD_NOP;
    localparam state_timer_pkg::ctrl_cmd_t    GET = state_timer_pkg::CMD_GET;
    localparam state_timer_pkg::ctrl_cmd_t    SET = state_timer_pkg::CMD_SET;
    localparam state_timer_pkg::ctrl_cmd_t    CLR = state_timer_pkg::CMD_CLEAR;
    localparam state_timer_pkg::ctrl_status_t OK  = state_timer_pkg::STATUS_OK;
    localparam state_timer_pkg::ctrl_status_t ERR = state_timer_pkg::STATUS_ERROR;

    // Step kinds: fixed ticks, random ticks, one update, four updates, control
    typedef enum int {K_TICK, K_RTICK, K_UPD, K_UPD4, K_CTRL} step_kind_t;

    // exp_val below zero means the reference model supplies the value
    typedef struct {
        int                            test;
        step_kind_t                    kind;
        int                            id;
        state_timer_pkg::ctrl_cmd_t    cmd;
        int                            ticks;
        int                            exp_val;
        state_timer_pkg::ctrl_status_t exp_status;
    } step_t;

    // ------------------------------------------------------------------------
    // DUT signals and reference model state
    // ------------------------------------------------------------------------

    logic                          clk;
    logic                          srst;
    logic                          tick;
    logic                          upd_valid;
    state_timer_pkg::id_t          upd_id;
    logic                          upd_credit;
    logic                          init_done;
    logic                          ctrl_req;
    state_timer_pkg::ctrl_cmd_t    ctrl_cmd;
    state_timer_pkg::id_t          ctrl_key;
    logic                          ctrl_rdy;
    logic                          ctrl_ack;
    state_timer_pkg::ctrl_status_t ctrl_status;
    logic                          ctrl_get_valid;
    state_timer_pkg::timer_t       ctrl_get_value;

    step_t                         steps [$];
    string                         test_names [6] = '{"reset sweep", "update stamps",
        "set and clear", "credit flow", "nop and ack latency", "timer wrap"};
    state_timer_pkg::timer_t       model_timer;
    state_timer_pkg::timer_t       stamps [DEPTH];
    int                            credits;
    int                            pulses;
    int                            errors;
    int                            test_base;
    int                            tests_passed;
    int                            tests_failed;
    int                            cur_test;
    int unsigned                   lcg_state = 32'h19cf0b0e;

    tb_clk_gen clk_gen_inst (
        .clk (clk)
    );

    state_timer_top state_timer_top_inst (
        .clk            (clk),
        .srst           (srst),
        .tick           (tick),
        .upd_valid      (upd_valid),
        .upd_id         (upd_id),
        .upd_credit     (upd_credit),
        .init_done      (init_done),
        .ctrl_req       (ctrl_req),
        .ctrl_cmd       (ctrl_cmd),
        .ctrl_key       (ctrl_key),
        .ctrl_rdy       (ctrl_rdy),
        .ctrl_ack       (ctrl_ack),
        .ctrl_status    (ctrl_status),
        .ctrl_get_valid (ctrl_get_valid),
        .ctrl_get_value (ctrl_get_value)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic void add_step(int test, step_kind_t kind, int id,
                                     state_timer_pkg::ctrl_cmd_t cmd, int ticks,
                                     int exp_val, state_timer_pkg::ctrl_status_t exp_status);
        step_t s;
        s.test       = test;
        s.kind       = kind;
        s.id         = id;
        s.cmd        = cmd;
        s.ticks      = ticks;
        s.exp_val    = exp_val;
        s.exp_status = exp_status;
        steps.push_back(s);
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic timeout_abort(input string what);
        $display("Timeout at %0t ns: no %s within the wait limit", $time, what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // Tick held high for n edges, the timer counts each one
    task automatic run_ticks(input int n);
        tick = 1'b1;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
        tick = 1'b0;
        model_timer = model_timer + state_timer_pkg::timer_t'(n);
    endtask

    // One update cycle, stamp taken while tick stays low
    task automatic send_update(input int id);
        if (credits == 0) begin
            errors++;
            $display("Sender has no credit left for update of id %0d at %0t ns", id, $time);
        end else begin
            upd_valid = 1'b1;
            upd_id    = state_timer_pkg::id_t'(id);
            credits--;
            stamps[id] = model_timer;
            @(negedge clk);
            if (upd_credit === 1'b1) begin
                credits++;
                pulses++;
            end
            @(posedge clk);
            #1;
            upd_valid = 1'b0;
        end
    endtask

    // Collect returned credits until the sender is full again
    task automatic wait_credits();
        int n;
        n = 0;
        while (credits != UPD_CREDITS && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (upd_credit === 1'b1) begin
                credits++;
                pulses++;
            end
            n++;
        end
        if (credits != UPD_CREDITS) begin
            timeout_abort("upd_credit");
        end
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------------------
    // Control request with reference model check
    // ------------------------------------------------------------------------

    task automatic do_ctrl(input step_t s);
        int                      n;
        int                      lat;
        logic                    exp_gv;
        state_timer_pkg::timer_t expected;
        ctrl_req = 1'b1;
        ctrl_cmd = s.cmd;
        ctrl_key = state_timer_pkg::id_t'(s.id);
        n = 0;
        @(negedge clk);
        while (ctrl_rdy !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ctrl_rdy !== 1'b1) begin
            timeout_abort("ctrl_rdy");
        end else begin
            // Accepted on the coming edge, count cycles to ack from there
            @(posedge clk);
            #1;
            ctrl_req = 1'b0;
            lat = 1;
            @(negedge clk);
            // Only one request outstanding, rdy low until the ack
            if (ctrl_rdy !== 1'b0) begin
                report_mismatch($sformatf("cmd %0d id %0d rdy high before ack", s.cmd, s.id));
            end
            while (ctrl_ack !== 1'b1 && lat < WAIT_LIMIT) begin
                @(negedge clk);
                lat++;
            end
            if (ctrl_ack !== 1'b1) begin
                timeout_abort("ctrl_ack");
            end else begin
                // Delta is modulo 2^16, tick held low so the timer is exact
                expected = model_timer - stamps[s.id];
                if (s.exp_val >= 0) begin
                    expected = state_timer_pkg::timer_t'(s.exp_val);
                end
                exp_gv = (s.cmd == GET);
                if (lat != 2) begin
                    report_mismatch($sformatf("ack %0d cycles after accept, expected 2", lat));
                end
                if (ctrl_status !== s.exp_status) begin
                    report_mismatch($sformatf("cmd %0d id %0d status %0d expected %0d",
                                              s.cmd, s.id, ctrl_status, s.exp_status));
                end
                if (ctrl_get_valid !== exp_gv) begin
                    report_mismatch($sformatf("cmd %0d id %0d get_valid %b expected %b",
                                              s.cmd, s.id, ctrl_get_valid, exp_gv));
                end
                if (exp_gv && ctrl_get_value !== expected) begin
                    report_mismatch($sformatf("GET id %0d delta %0d expected %0d",
                                              s.id, ctrl_get_value, expected));
                end
                if (s.cmd == SET) begin
                    stamps[s.id] = model_timer;
                end else if (s.cmd == CLR) begin
                    stamps[s.id] = '0;
                end
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic run_step(input step_t s);
        case (s.kind)
            K_TICK:  run_ticks(s.ticks);
            K_RTICK: run_ticks(int'((lcg_next() >> 8) % 32'd61) + 1);
            K_UPD: begin
                send_update(s.id);
                wait_credits();
            end
            K_UPD4: begin
                pulses = 0;
                for (int k = 0; k < UPD_CREDITS; k++) begin
                    send_update(s.id + k);
                end
                wait_credits();
                // Queue is empty now, any further credit is spurious
                repeat (3) begin
                    @(negedge clk);
                    if (upd_credit === 1'b1) begin
                        pulses++;
                    end
                end
                if (pulses != UPD_CREDITS) begin
                    report_mismatch($sformatf("%0d credit pulses, expected %0d",
                                              pulses, UPD_CREDITS));
                end
                @(posedge clk);
                #1;
            end
            default: do_ctrl(s);
        endcase
    endtask

    task automatic report_test(input int t);
        if (errors == test_base) begin
            tests_passed++;
            $display("Test %0d %s: pass", t, test_names[t-1]);
        end else begin
            tests_failed++;
            $display("Test %0d %s: fail with %0d errors", t, test_names[t-1], errors - test_base);
        end
        test_base = errors;
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------

    function automatic void build_table();
        add_step(1, K_TICK,  0,   NOP, 37,    -1,   OK);
        add_step(1, K_CTRL,  90,  GET, 0,     37,   OK);
        add_step(1, K_CTRL,  255, GET, 0,     -1,   OK);
        add_step(2, K_UPD,   3,   NOP, 0,     -1,   OK);
        add_step(2, K_RTICK, 0,   NOP, 0,     -1,   OK);
        add_step(2, K_UPD,   17,  NOP, 0,     -1,   OK);
        add_step(2, K_RTICK, 0,   NOP, 0,     -1,   OK);
        add_step(2, K_UPD,   200, NOP, 0,     -1,   OK);
        add_step(2, K_RTICK, 0,   NOP, 0,     -1,   OK);
        add_step(2, K_CTRL,  3,   GET, 0,     -1,   OK);
        add_step(2, K_CTRL,  17,  GET, 0,     -1,   OK);
        add_step(2, K_CTRL,  200, GET, 0,     -1,   OK);
        add_step(3, K_RTICK, 0,   NOP, 0,     -1,   OK);
        add_step(3, K_CTRL,  17,  SET, 0,     -1,   OK);
        add_step(3, K_CTRL,  17,  GET, 0,     0,    OK);
        add_step(3, K_RTICK, 0,   NOP, 0,     -1,   OK);
        add_step(3, K_CTRL,  200, CLR, 0,     -1,   OK);
        add_step(3, K_CTRL,  200, GET, 0,     -1,   OK);
        add_step(3, K_TICK,  0,   NOP, 5,     -1,   OK);
        add_step(3, K_CTRL,  17,  GET, 0,     -1,   OK);
        add_step(4, K_TICK,  0,   NOP, 9,     -1,   OK);
        add_step(4, K_UPD4,  40,  NOP, 0,     -1,   OK);
        add_step(4, K_CTRL,  40,  GET, 0,     0,    OK);
        add_step(4, K_CTRL,  43,  GET, 0,     0,    OK);
        add_step(4, K_TICK,  0,   NOP, 3,     -1,   OK);
        add_step(4, K_CTRL,  41,  GET, 0,     3,    OK);
        add_step(4, K_CTRL,  42,  GET, 0,     -1,   OK);
        add_step(5, K_CTRL,  7,   NOP, 0,     -1,   ERR);
        add_step(5, K_CTRL,  3,   GET, 0,     -1,   OK);
        add_step(6, K_UPD,   99,  NOP, 0,     -1,   OK);
        add_step(6, K_TICK,  0,   NOP, 70000, -1,   OK);
        add_step(6, K_CTRL,  99,  GET, 0,     4464, OK);
        add_step(6, K_CTRL,  3,   GET, 0,     -1,   OK);
    endfunction

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        int n;
        srst         = 1'b1;
        tick         = 1'b0;
        upd_valid    = 1'b0;
        upd_id       = '0;
        ctrl_req     = 1'b0;
        ctrl_cmd     = NOP;
        ctrl_key     = '0;
        model_timer  = '0;
        credits      = 0;
        pulses       = 0;
        errors       = 0;
        test_base    = 0;
        tests_passed = 0;
        tests_failed = 0;
        foreach (stamps[i]) begin
            stamps[i] = '0;
        end
        build_table();

        // Reset held for 16 edges, outputs checked quiet on the last one
        repeat (15) @(posedge clk);
        @(negedge clk);
        if (ctrl_rdy !== 1'b0 || ctrl_ack !== 1'b0 || ctrl_get_valid !== 1'b0 ||
            upd_credit !== 1'b0) begin
            report_mismatch("outputs not held low during reset");
        end
        @(posedge clk);
        #1;
        srst = 1'b0;

        // Sweep takes one cycle per entry, no request taken meanwhile
        n = 0;
        while (init_done !== 1'b1 && n < INIT_LIMIT) begin
            @(negedge clk);
            if (init_done !== 1'b1 && ctrl_rdy !== 1'b0) begin
                report_mismatch("ctrl_rdy high before init_done");
            end
            n++;
        end
        if (init_done !== 1'b1) begin
            timeout_abort("init_done");
        end
        @(posedge clk);
        #1;
        credits = UPD_CREDITS;

        cur_test = steps[0].test;
        foreach (steps[i]) begin
            if (steps[i].test != cur_test) begin
                report_test(cur_test);
                cur_test = steps[i].test;
            end
            run_step(steps[i]);
        end
        report_test(cur_test);

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : state_timer_tb

/* project.f */
+incdir+include
hw/state_timer_pkg.sv
hw/state_ctrl_intf.sv
hw/state_db_intf.sv
hw/state_db_ram.sv
hw/state_core.sv
hw/state_timer_core.sv
hw/state_timer_top.sv
sim/tb_clk_gen.sv
sim/state_timer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the state timer testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module state_timer_tb -o state_timer_sim -f project.f \
    && ./obj_dir/state_timer_sim > "$log" 2>&1 \
    || { echo "Build or simulation run failed"; cat "$log" 2>/dev/null; exit 1; }

cat "$log"

grep -q '\*\*\* TEST PASSED \*\*\*' "$log" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
